//--- kbd_controller.f
hdl/kbd_pkg.sv
hdl/kbd_read_if.sv
hdl/ps2_frame_receiver.sv
hdl/kbd_gray_fifo.sv
hdl/kbd_core_reader.sv
hdl/kbd_controller.sv
tests/kbd_controller_asserts.sv
tests/kbd_controller_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module kbd_controller_tb -f kbd_controller.f -o kbd_sim

out=$(./obj_dir/kbd_sim 2>&1) || true
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"

//--- tests/kbd_controller_tb.sv
`timescale 1ns/1ps

module kbd_controller_tb;

  // one kbd_clk phase and one full frame
  localparam int kbd_half_ns  = 40;
  localparam int frame_ns     = kbd_pkg::frame_bits * 2 * kbd_half_ns;
  // frames sent over all tests including filler frames
  localparam int total_frames = 41;
  // bound in core cycles on any wait for a dut output
  localparam int wait_limit   = 200;

  logic                       kbd_clk;
  logic                       kbd_data;
  logic                       core_clk;
  logic                       rst;
  logic                       scanf_en;
  logic                       read_en;
  logic [kbd_pkg::code_w-1:0] data_out;
  logic                       extension;
  logic                       valid;
  logic                       error;
  logic                       data_ready;

  kbd_controller dut (
    .kbd_clk    (kbd_clk),
    .kbd_data   (kbd_data),
    .core_clk   (core_clk),
    .rst        (rst),
    .scanf_en   (scanf_en),
    .read_en    (read_en),
    .data_out   (data_out),
    .extension  (extension),
    .valid      (valid),
    .error      (error),
    .data_ready (data_ready)
  );

  initial begin
    core_clk = 1'b0;
    forever #5 core_clk = ~core_clk;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  // one keyboard clock cycle carrying one bit
  // kbd_clk rises between core edges well after the data change
  task automatic kbd_tick(input logic bit_val);
    @(posedge core_clk);
    kbd_data <= bit_val;
    #13 kbd_clk = 1'b1;
    #kbd_half_ns kbd_clk = 1'b0;
    #(kbd_half_ns - 20);
  endtask

  // start, data lsb first, odd parity, stop
  task automatic send_frame(input logic [7:0] data_byte, input logic bad_parity = 1'b0);
    logic parity;
    parity = ~^data_byte;
    if (bad_parity)
      parity = ~parity;
    kbd_tick(1'b0);
    for (int i = 0; i < kbd_pkg::code_w; i++)
      kbd_tick(data_byte[i]);
    kbd_tick(parity);
    kbd_tick(1'b1);
  endtask

  function automatic logic [7:0] random_code();
    logic [7:0] code;
    code = 8'($urandom);
    // prefixes are not key codes
    while (code == kbd_pkg::break_code || code == kbd_pkg::ext_code)
      code = 8'($urandom);
    return code;
  endfunction

  task automatic send_release(input logic [7:0] code, input logic ext);
    if (ext)
      send_frame(kbd_pkg::ext_code);
    send_frame(kbd_pkg::break_code);
    send_frame(code);
  endtask

  // the fifo write lands on the kbd_clk edge after the stop bit
  // so a following make code clocks it in
  task automatic send_filler();
    send_frame(random_code());
  endtask

  task automatic wait_for_ready();
    int cycles;
    cycles = 0;
    while (!data_ready && cycles < wait_limit) begin
      @(negedge core_clk);
      cycles++;
    end
    assert (data_ready) else report_failure("data_ready never rose for an expected entry");
  endtask

  task automatic wait_for_error(input logic level);
    int cycles;
    cycles = 0;
    while (error !== level && cycles < 8) begin
      @(negedge core_clk);
      cycles++;
    end
    assert (error === level) else
      report_failure($sformatf("Mismatch at %0d ns: error expected %0b, got %0b",
                               $time, level, error));
  endtask

  // one read request then a check of the popped entry while valid is high
  task automatic read_and_check(input logic [7:0] exp_code, input logic exp_ext);
    int cycles;
    wait_for_ready();
    @(posedge core_clk);
    read_en <= 1'b1;
    @(posedge core_clk);
    read_en <= 1'b0;
    cycles = 0;
    @(negedge core_clk);
    while (!valid && cycles < wait_limit) begin
      @(negedge core_clk);
      cycles++;
    end
    assert (valid) else report_failure("valid never pulsed after a read request");
    assert (data_out == exp_code) else
      report_failure($sformatf("Mismatch at %0d ns: data_out expected %02h, got %02h",
                               $time, exp_code, data_out));
    assert (extension == exp_ext) else
      report_failure($sformatf("Mismatch at %0d ns: extension expected %0b, got %0b",
                               $time, exp_ext, extension));
  endtask

  task automatic expect_no_entry(input int cycles);
    repeat (cycles) begin
      @(negedge core_clk);
      assert (!data_ready) else
        report_failure($sformatf("Mismatch at %0d ns: data_ready expected 0, got %0b",
                                 $time, data_ready));
    end
  endtask

  // kbd_clk ticks with the line idle so the synchronized reset reaches the receiver
  task automatic reset_dut();
    fork
      begin
        repeat (16) @(posedge core_clk);
        rst <= 1'b0;
      end
      repeat (2) kbd_tick(1'b1);
    join
    // release of rst still has to pass the two kbd_clk flops
    repeat (2) kbd_tick(1'b1);
    // outputs start cleared before any read
    assert (data_out == '0) else
      report_failure($sformatf("Mismatch at %0d ns: data_out expected 00, got %02h",
                               $time, data_out));
    assert (extension == 1'b0) else
      report_failure($sformatf("Mismatch at %0d ns: extension expected 0, got %0b",
                               $time, extension));
  endtask

  task automatic plain_key_release();
    logic [7:0] code;
    code = random_code();
    send_frame(code);
    send_release(code, 1'b0);
    send_filler();
    read_and_check(code, 1'b0);
    expect_no_entry(20);
  endtask

  task automatic extended_key_release();
    logic [7:0] code;
    code = random_code();
    send_frame(kbd_pkg::ext_code);
    send_frame(code);
    send_release(code, 1'b1);
    send_filler();
    read_and_check(code, 1'b1);
    expect_no_entry(20);
  endtask

  task automatic bad_frame_recovery();
    logic [7:0] code;
    code = random_code();
    // bad parity after F0 drops the pending release
    send_frame(kbd_pkg::break_code);
    send_frame(code, 1'b1);
    wait_for_error(1'b1);
    send_frame(code);
    wait_for_error(1'b0);
    send_filler();
    expect_no_entry(20);
    send_release(code, 1'b0);
    send_filler();
    read_and_check(code, 1'b0);
  endtask

  task automatic capture_disabled();
    @(posedge core_clk);
    scanf_en <= 1'b0;
    send_release(random_code(), 1'b0);
    send_filler();
    expect_no_entry(100);
    @(posedge core_clk);
    scanf_en <= 1'b1;
  endtask

  task automatic fifo_order_and_overflow();
    logic [7:0] sent[$];
    logic [7:0] code;
    // one release more than the fifo holds so the last is lost
    for (int k = 0; k < kbd_pkg::fifo_depth + 1; k++) begin
      code = random_code();
      sent.push_back(code);
      send_release(code, 1'b0);
    end
    send_filler();
    for (int k = 0; k < kbd_pkg::fifo_depth; k++)
      read_and_check(sent[k], 1'b0);
    expect_no_entry(20);
  endtask

  task automatic press_without_release();
    send_frame(random_code());
    send_filler();
    expect_no_entry(40);
  endtask

  initial begin
    #(total_frames * frame_ns * 2);
    report_failure("timeout: the tests did not finish within the watchdog limit");
  end

  initial begin
    kbd_clk  = 1'b0;
    kbd_data = 1'b1;
    rst      = 1'b1;
    scanf_en = 1'b1;
    read_en  = 1'b0;
    void'($urandom(72));
    reset_dut();
    plain_key_release();
    extended_key_release();
    bad_frame_recovery();
    capture_disabled();
    fifo_order_and_overflow();
    press_without_release();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- tests/kbd_controller_asserts.sv
`timescale 1ns/1ps

module kbd_controller_asserts (
  input logic core_clk,
  input logic rst,
  input logic read_en,
  input logic valid,
  input logic error,
  input logic data_ready
);

  // valid is a single cycle strobe
  assert property (@(posedge core_clk) disable iff (rst) valid |=> !valid)
    else $error("valid stayed high for more than one cycle");

  // a pop needs a request while an entry was waiting
  assert property (@(posedge core_clk) disable iff (rst)
                   valid |-> $past(read_en && data_ready))
    else $error("valid without a read request on a non empty fifo");

  // outputs come out of reset quiet
  assert property (@(posedge core_clk) rst |=> !valid && !error && !data_ready)
    else $error("valid, error or data_ready high during reset");

endmodule

bind kbd_controller kbd_controller_asserts u_asserts (
  .core_clk   (core_clk),
  .rst        (rst),
  .read_en    (read_en),
  .valid      (valid),
  .error      (error),
  .data_ready (data_ready)
);

//--- hdl/kbd_controller.sv
`timescale 1ns/1ps

module kbd_controller (
  input  logic                       kbd_clk,
  input  logic                       kbd_data,
  input  logic                       core_clk,
  input  logic                       rst,
  input  logic                       scanf_en,
  input  logic                       read_en,
  output logic [kbd_pkg::code_w-1:0] data_out,
  output logic                       extension,
  output logic                       valid,
  output logic                       error,
  output logic                       data_ready
);

  // core signals brought into kbd_clk
  logic rst_s1_q;
  logic rst_kbd;
  logic scanf_s1_q;
  logic scanf_en_kbd;

  // producer to fifo
  logic                wr_en;
  kbd_pkg::kbd_entry_t wr_entry;
  logic                frame_error;

  kbd_read_if rd_if ();

  // two flop synchronizers, shared by the receiver and the fifo write side
  always_ff @(posedge kbd_clk) begin
    rst_s1_q     <= rst;
    rst_kbd      <= rst_s1_q;
    scanf_s1_q   <= scanf_en;
    scanf_en_kbd <= scanf_s1_q;
  end

  ps2_frame_receiver u_receiver (
    .kbd_clk     (kbd_clk),
    .rst         (rst_kbd),
    .scanf_en    (scanf_en_kbd),
    .kbd_data    (kbd_data),
    .wr_en       (wr_en),
    .wr_entry    (wr_entry),
    .frame_error (frame_error)
  );

  kbd_gray_fifo u_fifo (
    .kbd_clk  (kbd_clk),
    .rst_kbd  (rst_kbd),
    .wr_en    (wr_en),
    .wr_entry (wr_entry),
    .core_clk (core_clk),
    .rd       (rd_if.fifo)
  );

  kbd_core_reader u_reader (
    .core_clk        (core_clk),
    .rst             (rst),
    .read_en         (read_en),
    .frame_error_kbd (frame_error),
    .rd              (rd_if.reader),
    .data_out        (data_out),
    .extension       (extension),
    .valid           (valid),
    .error           (error),
    .data_ready      (data_ready)
  );

endmodule

//--- hdl/kbd_core_reader.sv
`timescale 1ns/1ps

module kbd_core_reader (
  input  logic                       core_clk,
  input  logic                       rst,
  input  logic                       read_en,
  input  logic                       frame_error_kbd,
  kbd_read_if.reader                 rd,
  output logic [kbd_pkg::code_w-1:0] data_out,
  output logic                       extension,
  output logic                       valid,
  output logic                       error,
  output logic                       data_ready
);

  // first stage of the error synchronizer
  logic err_s1_q;

  // fifo read side runs on the core reset
  assign rd.rst_core = rst;

  // pop only when there is something to pop
  assign rd.rd_en = read_en && !rd.empty;

  // level seen by software
  assign data_ready = !rd.empty;

  always_ff @(posedge core_clk) begin
    if (rst) begin
      data_out  <= '0;
      extension <= 1'b0;
      valid     <= 1'b0;
      err_s1_q  <= 1'b0;
      error     <= 1'b0;
    end else begin
      // one cycle strobe per popped entry
      valid <= rd.rd_en;
      if (rd.rd_en) begin
        // output holds until the next pop
        data_out  <= rd.rd_entry.code;
        extension <= rd.rd_entry.ext;
      end
      // frame error crosses from kbd_clk as a slow level
      err_s1_q <= frame_error_kbd;
      error    <= err_s1_q;
    end
  end

endmodule

//--- hdl/kbd_gray_fifo.sv
`timescale 1ns/1ps

module kbd_gray_fifo (
  input  logic                kbd_clk,
  input  logic                rst_kbd,
  input  logic                wr_en,
  input  kbd_pkg::kbd_entry_t wr_entry,
  input  logic                core_clk,
  kbd_read_if.fifo            rd
);

  // storage, written in kbd_clk and read in core_clk
  kbd_pkg::kbd_entry_t mem [kbd_pkg::fifo_depth];

  // write side pointers, one extra bit for wrap
  logic [kbd_pkg::fifo_addr_w:0] wr_bin_q;
  logic [kbd_pkg::fifo_addr_w:0] wr_bin_nxt;
  logic [kbd_pkg::fifo_addr_w:0] wr_gray_q;
  logic [kbd_pkg::fifo_addr_w:0] wr_gray_nxt;
  // read pointer seen from the write side
  logic [kbd_pkg::fifo_addr_w:0] rd_gray_s1_q;
  logic [kbd_pkg::fifo_addr_w:0] rd_gray_s2_q;

  // read side pointers
  logic [kbd_pkg::fifo_addr_w:0] rd_bin_q;
  logic [kbd_pkg::fifo_addr_w:0] rd_bin_nxt;
  logic [kbd_pkg::fifo_addr_w:0] rd_gray_q;
  logic [kbd_pkg::fifo_addr_w:0] rd_gray_nxt;
  // write pointer seen from the read side
  logic [kbd_pkg::fifo_addr_w:0] wr_gray_s1_q;
  logic [kbd_pkg::fifo_addr_w:0] wr_gray_s2_q;

  logic full;
  logic empty;
  logic push;
  logic pop;

  // full when the gray pointers differ only in the top two bits
  assign full = wr_gray_q == {~rd_gray_s2_q[kbd_pkg::fifo_addr_w -: 2],
                              rd_gray_s2_q[kbd_pkg::fifo_addr_w-2:0]};
  // writes into a full fifo are lost
  assign push = wr_en && !full;

  assign wr_bin_nxt  = wr_bin_q + {{kbd_pkg::fifo_addr_w{1'b0}}, push};
  assign wr_gray_nxt = wr_bin_nxt ^ (wr_bin_nxt >> 1);

  always_ff @(posedge kbd_clk) begin
    if (push)
      mem[wr_bin_q[kbd_pkg::fifo_addr_w-1:0]] <= wr_entry;
  end

  // write pointers and read pointer sync
  always_ff @(posedge kbd_clk) begin
    if (rst_kbd) begin
      wr_bin_q     <= '0;
      wr_gray_q    <= '0;
      rd_gray_s1_q <= '0;
      rd_gray_s2_q <= '0;
    end else begin
      wr_bin_q     <= wr_bin_nxt;
      wr_gray_q    <= wr_gray_nxt;
      rd_gray_s1_q <= rd_gray_q;
      rd_gray_s2_q <= rd_gray_s1_q;
    end
  end

  // empty when both gray pointers match
  assign empty = rd_gray_q == wr_gray_s2_q;
  assign pop   = rd.rd_en && !empty;

  assign rd_bin_nxt  = rd_bin_q + {{kbd_pkg::fifo_addr_w{1'b0}}, pop};
  assign rd_gray_nxt = rd_bin_nxt ^ (rd_bin_nxt >> 1);

  // head entry is visible without a read strobe
  assign rd.empty    = empty;
  assign rd.rd_entry = mem[rd_bin_q[kbd_pkg::fifo_addr_w-1:0]];

  // read pointers and write pointer sync
  always_ff @(posedge core_clk) begin
    if (rd.rst_core) begin
      rd_bin_q     <= '0;
      rd_gray_q    <= '0;
      wr_gray_s1_q <= '0;
      wr_gray_s2_q <= '0;
    end else begin
      rd_bin_q     <= rd_bin_nxt;
      rd_gray_q    <= rd_gray_nxt;
      wr_gray_s1_q <= wr_gray_q;
      wr_gray_s2_q <= wr_gray_s1_q;
    end
  end

endmodule

//--- hdl/ps2_frame_receiver.sv
`timescale 1ns/1ps

module ps2_frame_receiver (
  input  logic                kbd_clk,
  input  logic                rst,
  input  logic                scanf_en,
  input  logic                kbd_data,
  output logic                wr_en,
  output kbd_pkg::kbd_entry_t wr_entry,
  output logic                frame_error
);

  // first ten bits of the frame collected so far
  logic [kbd_pkg::frame_bits-2:0]         shift_q;
  // full frame as seen on the current edge
  logic [kbd_pkg::frame_bits-1:0]         frame;
  logic [$clog2(kbd_pkg::frame_bits)-1:0] bit_cnt_q;
  logic                                   frame_done;
  logic                                   frame_ok;
  logic [kbd_pkg::code_w-1:0]             rx_byte;
  kbd_pkg::rx_state_t                     state_q;
  kbd_pkg::rx_state_t                     state_nxt;
  logic                                   release_hit;

  // lsb arrives first so new bits enter at the top
  assign frame   = {kbd_data, shift_q};
  assign rx_byte = frame[kbd_pkg::code_w:1];

  // stop bit is being sampled on this edge
  assign frame_done =
    bit_cnt_q == ($clog2(kbd_pkg::frame_bits))'(kbd_pkg::frame_bits - 1);

  // start low, stop high, odd parity over data plus parity bit
  assign frame_ok = !frame[0] && frame[kbd_pkg::frame_bits-1] &&
                    (^frame[kbd_pkg::code_w+1:1]);

  // prefix decoder
  always_comb begin
    state_nxt   = kbd_pkg::rx_idle;
    release_hit = 1'b0;
    case (state_q)
      kbd_pkg::rx_idle,
      kbd_pkg::rx_ext: begin
        if (rx_byte == kbd_pkg::ext_code)
          state_nxt = kbd_pkg::rx_ext;
        else if (rx_byte == kbd_pkg::break_code)
          state_nxt = (state_q == kbd_pkg::rx_ext) ? kbd_pkg::rx_ext_break
                                                    : kbd_pkg::rx_break;
        // a plain make code just falls back to idle
      end
      default: begin
        // repeated prefix inside a release keeps waiting for the code
        if (rx_byte == kbd_pkg::ext_code || rx_byte == kbd_pkg::break_code)
          state_nxt = state_q;
        else
          release_hit = 1'b1;
      end
    endcase
  end

  // serial shifter
  always_ff @(posedge kbd_clk) begin
    shift_q <= frame[kbd_pkg::frame_bits-1:1];
  end

  // bit counter, decoder state and write strobe
  always_ff @(posedge kbd_clk) begin
    if (rst) begin
      bit_cnt_q   <= '0;
      state_q     <= kbd_pkg::rx_idle;
      wr_en       <= 1'b0;
      frame_error <= 1'b0;
    end else begin
      wr_en <= 1'b0;
      if (frame_done) begin
        bit_cnt_q <= '0;
        if (!frame_ok) begin
          // broken frame, drop any pending prefix
          frame_error <= 1'b1;
          state_q     <= kbd_pkg::rx_idle;
        end else begin
          frame_error <= 1'b0;
          state_q     <= state_nxt;
          // keys released while capture is off are discarded here
          wr_en       <= release_hit && scanf_en;
        end
      end else begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

  // entry payload, only meaningful with wr_en
  always_ff @(posedge kbd_clk) begin
    if (frame_done) begin
      wr_entry.ext  <= (state_q == kbd_pkg::rx_ext_break);
      wr_entry.code <= rx_byte;
    end
  end

endmodule

//--- hdl/kbd_read_if.sv
`timescale 1ns/1ps

// read side of the keyboard fifo toward the core reader
interface kbd_read_if;

  // pop request and core reset come from the reader
  logic                rd_en;
  logic                rst_core;
  // head of the fifo and its empty flag come back
  logic                empty;
  kbd_pkg::kbd_entry_t rd_entry;

  modport fifo (
    input  rd_en,
    input  rst_core,
    output empty,
    output rd_entry
  );

  modport reader (
    output rd_en,
    output rst_core,
    input  empty,
    input  rd_entry
  );

endinterface

//--- hdl/kbd_pkg.sv
package kbd_pkg;

  // scan code width and serial frame length
  // a frame is start, eight data bits, parity and stop
  localparam int code_w     = 8;
  localparam int frame_bits = 11;

  // prefix bytes sent by the keyboard
  // F0 precedes a released code and E0 marks an extended key
  localparam logic [code_w-1:0] break_code = 8'hf0;
  localparam logic [code_w-1:0] ext_code   = 8'he0;

  // fifo sizing
  localparam int fifo_addr_w = 3;
  localparam int fifo_depth  = 1 << fifo_addr_w;

  // prefix decoder states
  typedef enum logic [1:0] {
    rx_idle,
    // E0 seen
    rx_ext,
    // F0 seen
    rx_break,
    // E0 then F0 seen
    rx_ext_break
  } rx_state_t;

  // one fifo word
  // ext sits above the scan code
  typedef struct packed {
    logic              ext;
    logic [code_w-1:0] code;
  } kbd_entry_t;

endpackage
